// ==== src/mem_ctrl_cfg.svh ====
//////////////////////////////
// Memory bus controller constants
//////////////////////////////
`ifndef MEM_CTRL_CFG_SVH
`define MEM_CTRL_CFG_SVH

// Data path geometry
`define MEM_BEAT_W          32
`define MEM_LINE_BEATS      4
`define MEM_LINE_W          128
`define MEM_LINES           64

// Access latency after reset, in clock cycles
`define MEM_DEFAULT_LATENCY 3

// Configuration register map
`define MEM_REG_LATENCY     2'd0
`define MEM_REG_RD_COUNT    2'd1
`define MEM_REG_WR_COUNT    2'd2

`endif

// ==== src/mem_ctrl_pkg.sv ====
//////////////////////////////
// Memory bus controller types
// Requester tags, requests and read returns
//////////////////////////////
`default_nettype none

`include "mem_ctrl_cfg.svh"

package mem_ctrl_pkg;

   // Requester tag, carried back on every response beat
   typedef enum logic [1:0]
   {
      src_ic  = 2'd0,
      src_dc  = 2'd1,
      src_dma = 2'd2
   } mem_src_e;

   // One 16-byte memory line
   typedef logic [`MEM_LINE_W-1:0] mem_line_t;

   // Request as it travels through the latch stages
   // Size code holds byte count minus one
   typedef struct packed
   {
      logic      write;
      logic [15:0] addr;
      logic [3:0]  size;
      mem_src_e  src;
      mem_line_t line;
   } bus_req_t;

   // Line returned by a read, tagged with its requester
   typedef struct packed
   {
      mem_src_e  src;
      mem_line_t line;
   } mem_rd_t;

endpackage

`default_nettype wire

// ==== src/mem_beat_assembler.sv ====
//////////////////////////////
// Request header and write beat assembler
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_beat_assembler (
   input  logic                     clk,
   input  logic                     rst_n,
   input  logic                     req_valid,
   output logic                     req_ready,
   input  logic                     req_write,
   input  logic [15:0]              req_addr,
   input  logic [3:0]               req_size,
   input  mem_ctrl_pkg::mem_src_e   req_src,
   input  logic                     wdata_valid,
   output logic                     wdata_ready,
   input  logic [`MEM_BEAT_W-1:0]   wdata,
   output logic                     out_valid,
   input  logic                     out_ready,
   output mem_ctrl_pkg::bus_req_t   out_req
);
   import mem_ctrl_pkg::*;

   localparam int CNT_W = $clog2(`MEM_LINE_BEATS);

   typedef enum logic [1:0] {st_idle, st_collect, st_offer} state_e;

   state_e           state_q;
   logic [CNT_W-1:0] beat_q;
   bus_req_t         req_q;

   assign req_ready   = (state_q == st_idle);
   assign wdata_ready = (state_q == st_collect);
   assign out_valid   = (state_q == st_offer);
   assign out_req     = req_q;

   // Reads go straight to offer, writes wait for their four beats
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= st_idle;
         beat_q  <= '0;
      end
      else
      begin
         case (state_q)
            st_idle:
               if (req_valid)
               begin
                  beat_q  <= '0;
                  state_q <= req_write ? st_collect : st_offer;
               end
            st_collect:
               if (wdata_valid)
               begin
                  beat_q <= beat_q + 1'b1;
                  if (beat_q == CNT_W'(`MEM_LINE_BEATS - 1))
                     state_q <= st_offer;
               end
            st_offer:
               if (out_ready)
                  state_q <= st_idle;
            default:
               state_q <= st_idle;
         endcase
      end
   end

   // Header capture, line cleared so reads carry zero data
   always_ff @(posedge clk)
   begin
      if (req_valid && req_ready)
      begin
         req_q.write <= req_write;
         req_q.addr  <= req_addr;
         req_q.size  <= req_size;
         req_q.src   <= req_src;
         req_q.line  <= '0;
      end
      else if (wdata_valid && wdata_ready)
         req_q.line[beat_q*`MEM_BEAT_W +: `MEM_BEAT_W] <= wdata;
   end

endmodule

`default_nettype wire

// ==== src/mem_req_latch.sv ====
//////////////////////////////
// Single-entry pipeline latch
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mem_req_latch #(
   parameter type payload_t = logic
) (
   input  logic     clk,
   input  logic     rst_n,
   input  logic     in_valid,
   output logic     in_ready,
   input  payload_t in_data,
   output logic     out_valid,
   input  logic     out_ready,
   output payload_t out_data
);

   logic     valid_q;
   payload_t data_q;

   // Room when empty or when the held entry leaves this cycle
   assign in_ready  = !valid_q || out_ready;
   assign out_valid = valid_q;
   assign out_data  = data_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         valid_q <= 1'b0;
      else if (in_ready)
         valid_q <= in_valid;
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
         data_q <= in_data;
   end

endmodule

`default_nettype wire

// ==== src/mem_bank_port.sv ====
//////////////////////////////
// Memory bank port
// Timed line access with shifted partial writes
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_bank_port (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   req_valid,
   output logic                   req_ready,
   input  mem_ctrl_pkg::bus_req_t req,
   input  logic [3:0]             latency,
   output logic                   rd_valid,
   input  logic                   rd_ready,
   output mem_ctrl_pkg::mem_rd_t  rd,
   output logic                   done_rd,
   output logic                   done_wr
);
   import mem_ctrl_pkg::*;

   localparam int IDX_W      = $clog2(`MEM_LINES);
   localparam int LINE_BYTES = `MEM_LINE_W / 8;

   typedef enum logic [1:0] {st_idle, st_busy, st_ret} state_e;

   state_e                state_q;
   logic [3:0]            timer_q;
   bus_req_t              req_q;
   mem_line_t             mem_q [`MEM_LINES];
   mem_line_t             rd_line_q;
   logic [IDX_W-1:0]      idx;
   logic [3:0]            offset;
   logic [LINE_BYTES-1:0] be;
   mem_line_t             shifted;
   mem_line_t             merged;
   logic                  finish;

   // Line index sits above the byte offset, upper bits alias
   assign idx    = req_q.addr[4 +: IDX_W];
   assign offset = req_q.addr[3:0];
   assign finish = (state_q == st_busy) && (timer_q == 4'd1);

   assign req_ready = (state_q == st_idle);
   assign rd_valid  = (state_q == st_ret);
   assign rd        = '{src: req_q.src, line: rd_line_q};
   assign done_wr   = finish && req_q.write;
   assign done_rd   = rd_valid && rd_ready;

   //////////////////////////////
   // Partial write merge
   //////////////////////////////
   always_comb
   begin
      logic [4:0] first;
      logic [4:0] last;
      first   = {1'b0, offset};
      last    = first + {1'b0, req_q.size};
      // Bytes pushed past the top of the line fall off
      shifted = req_q.line << {offset, 3'b000};
      merged  = mem_q[idx];
      for (int b = 0; b < LINE_BYTES; b++)
      begin
         be[b] = (5'(b) >= first) && (5'(b) <= last);
         if (be[b])
            merged[b*8 +: 8] = shifted[b*8 +: 8];
      end
   end

   //////////////////////////////
   // Access timer
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q <= st_idle;
         timer_q <= 4'd0;
      end
      else
      begin
         case (state_q)
            st_idle:
               if (req_valid)
               begin
                  // Zero latency behaves as one cycle
                  timer_q <= (latency == 4'd0) ? 4'd1 : latency;
                  state_q <= st_busy;
               end
            st_busy:
            begin
               timer_q <= timer_q - 4'd1;
               if (timer_q == 4'd1)
                  state_q <= req_q.write ? st_idle : st_ret;
            end
            st_ret:
               if (rd_ready)
                  state_q <= st_idle;
            default:
               state_q <= st_idle;
         endcase
      end
   end

   always_ff @(posedge clk)
   begin
      if (req_valid && req_ready)
         req_q <= req;
   end

   // Line array and read buffer
   always_ff @(posedge clk)
   begin
      if (finish)
      begin
         if (req_q.write)
            mem_q[idx] <= merged;
         else
            rd_line_q <= mem_q[idx];
      end
   end

endmodule

`default_nettype wire

// ==== src/mem_ctrl_regs.sv ====
//////////////////////////////
// Configuration and status registers
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_ctrl_regs (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        cfg_wr_en,
   input  logic [1:0]  cfg_addr,
   input  logic [15:0] cfg_wdata,
   output logic [15:0] cfg_rdata,
   input  logic        done_rd,
   input  logic        done_wr,
   output logic [3:0]  latency
);

   logic [3:0]  latency_q;
   logic [15:0] rd_count_q;
   logic [15:0] wr_count_q;

   assign latency = latency_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         latency_q  <= 4'(`MEM_DEFAULT_LATENCY);
         rd_count_q <= 16'd0;
         wr_count_q <= 16'd0;
      end
      else
      begin
         // Values above the field saturate at the longest latency
         if (cfg_wr_en && cfg_addr == `MEM_REG_LATENCY)
            latency_q <= (|cfg_wdata[15:4]) ? 4'hf : cfg_wdata[3:0];
         // A write of any value clears a counter
         if (cfg_wr_en && cfg_addr == `MEM_REG_RD_COUNT)
            rd_count_q <= 16'd0;
         else if (done_rd)
            rd_count_q <= rd_count_q + 16'd1;
         if (cfg_wr_en && cfg_addr == `MEM_REG_WR_COUNT)
            wr_count_q <= 16'd0;
         else if (done_wr)
            wr_count_q <= wr_count_q + 16'd1;
      end
   end

   always_comb
   begin
      case (cfg_addr)
         `MEM_REG_LATENCY:  cfg_rdata = {12'd0, latency_q};
         `MEM_REG_RD_COUNT: cfg_rdata = rd_count_q;
         `MEM_REG_WR_COUNT: cfg_rdata = wr_count_q;
         default:           cfg_rdata = 16'd0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/mem_resp_serializer.sv ====
//////////////////////////////
// Read response serializer
// Line out as four tagged beats
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_resp_serializer (
   input  logic                   clk,
   input  logic                   rst_n,
   input  logic                   in_valid,
   output logic                   in_ready,
   input  mem_ctrl_pkg::mem_rd_t  in_rd,
   output logic                   resp_valid,
   input  logic                   resp_ready,
   output logic [`MEM_BEAT_W-1:0] resp_data,
   output mem_ctrl_pkg::mem_src_e resp_dest,
   output logic                   resp_last
);
   import mem_ctrl_pkg::*;

   localparam int CNT_W = $clog2(`MEM_LINE_BEATS);

   logic             full_q;
   logic [CNT_W-1:0] beat_q;
   mem_rd_t          rd_q;

   // New line only once the previous one has fully drained
   assign in_ready   = !full_q;
   assign resp_valid = full_q;
   assign resp_data  = rd_q.line[beat_q*`MEM_BEAT_W +: `MEM_BEAT_W];
   assign resp_dest  = rd_q.src;
   assign resp_last  = (beat_q == CNT_W'(`MEM_LINE_BEATS - 1));

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         full_q <= 1'b0;
         beat_q <= '0;
      end
      else if (in_valid && in_ready)
      begin
         full_q <= 1'b1;
         beat_q <= '0;
      end
      else if (resp_valid && resp_ready)
      begin
         if (resp_last)
            full_q <= 1'b0;
         else
            beat_q <= beat_q + 1'b1;
      end
   end

   always_ff @(posedge clk)
   begin
      if (in_valid && in_ready)
         rd_q <= in_rd;
   end

endmodule

`default_nettype wire

// ==== src/mem_bus_ctrl_top.sv ====
//////////////////////////////
// Memory bus controller top level
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_bus_ctrl_top (
   input  logic                   clk,
   input  logic                   rst_n,
   // Request headers
   input  logic                   req_valid,
   output logic                   req_ready,
   input  logic                   req_write,
   input  logic [15:0]            req_addr,
   input  logic [3:0]             req_size,
   input  mem_ctrl_pkg::mem_src_e req_src,
   // Write data beats
   input  logic                   wdata_valid,
   output logic                   wdata_ready,
   input  logic [`MEM_BEAT_W-1:0] wdata,
   // Read responses
   output logic                   resp_valid,
   input  logic                   resp_ready,
   output logic [`MEM_BEAT_W-1:0] resp_data,
   output mem_ctrl_pkg::mem_src_e resp_dest,
   output logic                   resp_last,
   // Configuration port
   input  logic                   cfg_wr_en,
   input  logic [1:0]             cfg_addr,
   input  logic [15:0]            cfg_wdata,
   output logic [15:0]            cfg_rdata
);
   import mem_ctrl_pkg::*;

   logic       asm_valid, asm_ready;
   bus_req_t   asm_req;
   logic       wr_valid, wr_ready;
   bus_req_t   wr_req;
   logic       rd_valid, rd_ready;
   bus_req_t   rd_req;
   logic       bank_valid, bank_ready;
   mem_rd_t    bank_rd;
   logic       ret_valid, ret_ready;
   mem_rd_t    ret_rd;
   logic [3:0] latency;
   logic       done_rd, done_wr;

   mem_beat_assembler i_assembler (
      .clk, .rst_n,
      .req_valid, .req_ready, .req_write, .req_addr, .req_size, .req_src,
      .wdata_valid, .wdata_ready, .wdata,
      .out_valid(asm_valid), .out_ready(asm_ready), .out_req(asm_req)
   );

   //////////////////////////////
   // Write and read latch stages
   //////////////////////////////
   mem_req_latch #(.payload_t(bus_req_t)) i_wr_latch (
      .clk, .rst_n,
      .in_valid(asm_valid), .in_ready(asm_ready), .in_data(asm_req),
      .out_valid(wr_valid), .out_ready(wr_ready), .out_data(wr_req)
   );

   mem_req_latch #(.payload_t(bus_req_t)) i_rd_latch (
      .clk, .rst_n,
      .in_valid(wr_valid), .in_ready(wr_ready), .in_data(wr_req),
      .out_valid(rd_valid), .out_ready(rd_ready), .out_data(rd_req)
   );

   mem_bank_port i_bank_port (
      .clk, .rst_n,
      .req_valid(rd_valid), .req_ready(rd_ready), .req(rd_req),
      .latency,
      .rd_valid(bank_valid), .rd_ready(bank_ready), .rd(bank_rd),
      .done_rd, .done_wr
   );

   mem_ctrl_regs i_regs (
      .clk, .rst_n,
      .cfg_wr_en, .cfg_addr, .cfg_wdata, .cfg_rdata,
      .done_rd, .done_wr, .latency
   );

   // Return path toward the bus
   mem_req_latch #(.payload_t(mem_rd_t)) i_ret_latch (
      .clk, .rst_n,
      .in_valid(bank_valid), .in_ready(bank_ready), .in_data(bank_rd),
      .out_valid(ret_valid), .out_ready(ret_ready), .out_data(ret_rd)
   );

   mem_resp_serializer i_serializer (
      .clk, .rst_n,
      .in_valid(ret_valid), .in_ready(ret_ready), .in_rd(ret_rd),
      .resp_valid, .resp_ready, .resp_data, .resp_dest, .resp_last
   );

endmodule

`default_nettype wire

// ==== tb/mem_bus_ctrl_assert.sv ====
//////////////////////////////
// Protocol assertions for the memory bus controller
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_bus_ctrl_assert (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   req_valid,
   input logic                   req_ready,
   input logic                   req_write,
   input logic                   wdata_valid,
   input logic                   wdata_ready,
   input logic                   resp_valid,
   input logic                   resp_ready,
   input logic [`MEM_BEAT_W-1:0] resp_data,
   input mem_ctrl_pkg::mem_src_e resp_dest,
   input logic                   resp_last,
   input logic                   asm_valid,
   input logic                   wr_valid,
   input logic                   rd_valid,
   input logic                   bank_valid,
   input logic                   ret_valid
);

   // Counts response beats across all lines
   logic [1:0] beat_q;
   // Write in progress between its header and its fourth beat
   logic       collect_q;
   logic [1:0] wbeat_q;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         beat_q <= 2'd0;
      else if (resp_valid && resp_ready)
         beat_q <= beat_q + 2'd1;
   end

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         collect_q <= 1'b0;
         wbeat_q   <= 2'd0;
      end
      else if (req_valid && req_ready && req_write)
      begin
         collect_q <= 1'b1;
         wbeat_q   <= 2'd0;
      end
      else if (collect_q && wdata_valid && wdata_ready)
      begin
         wbeat_q <= wbeat_q + 2'd1;
         if (wbeat_q == 2'd3)
            collect_q <= 1'b0;
      end
   end

   a_resp_stable: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && !resp_ready |=> resp_valid && $stable(resp_data)
         && $stable(resp_dest) && $stable(resp_last))
      else $error("response changed while stalled");

   a_resp_last: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid && resp_ready |-> resp_last == (beat_q == 2'd3))
      else $error("resp_last not on the fourth beat");

   a_reset_idle: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(rst_n) |-> !(resp_valid || wdata_ready || asm_valid || wr_valid
         || rd_valid || bank_valid || ret_valid))
      else $error("valid high right after reset");

   a_collect_excl: assert property (@(posedge clk) disable iff (!rst_n)
      collect_q |-> wdata_ready && !req_ready)
      else $error("wdata_ready low or req_ready high while collecting write beats");

endmodule

bind mem_bus_ctrl_top mem_bus_ctrl_assert i_assert (
   .clk, .rst_n, .req_valid, .req_ready, .req_write, .wdata_valid, .wdata_ready,
   .resp_valid, .resp_ready, .resp_data, .resp_dest, .resp_last,
   .asm_valid, .wr_valid, .rd_valid, .bank_valid, .ret_valid
);

`default_nettype wire

// ==== tb/mem_bus_ctrl_tb.sv ====
//////////////////////////////
// Memory bus controller testbench
// Table of operations checked against a byte-level reference memory
//////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mem_ctrl_cfg.svh"

module mem_bus_ctrl_tb;
   import mem_ctrl_pkg::*;

   localparam int TIMEOUT   = 400;
   localparam int MAX_OPS   = 32;
   localparam int DRIVE_DLY = 2;

   typedef enum logic [1:0] {op_cfg, op_wr, op_rd} op_kind_e;

   logic                   clk;
   logic                   rst_n;
   logic                   req_valid;
   logic                   req_ready;
   logic                   req_write;
   logic [15:0]            req_addr;
   logic [3:0]             req_size;
   mem_src_e               req_src;
   logic                   wdata_valid;
   logic                   wdata_ready;
   logic [`MEM_BEAT_W-1:0] wdata;
   logic                   resp_valid;
   logic                   resp_ready;
   logic [`MEM_BEAT_W-1:0] resp_data;
   mem_src_e               resp_dest;
   logic                   resp_last;
   logic                   cfg_wr_en;
   logic [1:0]             cfg_addr;
   logic [15:0]            cfg_wdata;
   logic [15:0]            cfg_rdata;

   // Operation table
   op_kind_e    op_kind [MAX_OPS];
   logic [15:0] op_addr [MAX_OPS];
   logic [3:0]  op_size [MAX_OPS];
   mem_src_e    op_src  [MAX_OPS];
   mem_line_t   op_line [MAX_OPS];
   logic [15:0] op_lat  [MAX_OPS];
   mem_line_t   op_exp  [MAX_OPS];
   int          n_ops = 0;
   int          n_rd = 0;
   int          n_wr = 0;

   logic [7:0]  ref_mem [`MEM_LINES*16];
   mem_line_t   exp_lines [$];
   mem_src_e    exp_srcs [$];
   int          exp_ids [$];
   int          err_count = 0;
   int          test_count = 0;
   int          errs_before;
   integer      seed;

   mem_bus_ctrl_top i_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////
   // Reference model
   //////////////////////////////
   function automatic mem_line_t make_line(input logic [3:0] pat);
      mem_line_t l;
      for (int i = 0; i < 16; i++)
         l[i*8 +: 8] = {pat, 4'(i)};
      return l;
   endfunction

   // Low size+1 bytes land from the address offset upward, overflow is lost
   task automatic ref_write(input logic [15:0] addr, input logic [3:0] size,
                            input mem_line_t line);
      int base;
      int pos;
      base = (int'(addr[15:4]) % `MEM_LINES) * 16;
      for (int b = 0; b <= int'(size); b++)
      begin
         pos = int'(addr[3:0]) + b;
         if (pos < 16)
            ref_mem[base + pos] = line[b*8 +: 8];
      end
   endtask

   function automatic mem_line_t ref_read(input logic [15:0] addr);
      int        base;
      mem_line_t l;
      base = (int'(addr[15:4]) % `MEM_LINES) * 16;
      for (int i = 0; i < 16; i++)
         l[i*8 +: 8] = ref_mem[base + i];
      return l;
   endfunction

   task automatic add_op(input op_kind_e kind, input logic [15:0] addr,
                         input logic [3:0] size, input mem_src_e src,
                         input logic [3:0] pat, input logic [15:0] lat);
      op_kind[n_ops] = kind;
      op_addr[n_ops] = addr;
      op_size[n_ops] = size;
      op_src[n_ops]  = src;
      op_line[n_ops] = (kind == op_wr) ? make_line(pat) : '0;
      op_lat[n_ops]  = lat;
      if (kind == op_wr)
      begin
         ref_write(addr, size, op_line[n_ops]);
         n_wr++;
      end
      else if (kind == op_rd)
      begin
         op_exp[n_ops] = ref_read(addr);
         n_rd++;
      end
      n_ops++;
   endtask

   //////////////////////////////
   // Compare tasks
   //////////////////////////////
   task automatic check_line(input mem_line_t got, input mem_line_t exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_dest(input mem_src_e got, input mem_src_e exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_reg(input logic [15:0] got, input logic [15:0] exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %0d expected %0d", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic check_flag(input logic got, input logic exp, input string what);
      if (got !== exp)
      begin
         $display("[ERROR] %0t: %s got %b expected %b", $time, what, got, exp);
         err_count++;
      end
   endtask

   task automatic abort_run(input string what);
      $display("Timeout after %0d cycles waiting for %s", TIMEOUT, what);
      $display("Test failed");
      $finish;
   endtask

   task automatic report_test(input string name, input int errs);
      test_count++;
      $display("test %0d %s: %s", test_count, name, (err_count == errs) ? "ok" : "mismatch");
   endtask

   //////////////////////////////
   // Bus drivers
   //////////////////////////////
   task automatic send_header(input logic write, input logic [15:0] addr,
                              input logic [3:0] size, input mem_src_e src);
      int cnt;
      cnt = 0;
      @(posedge clk);
      #DRIVE_DLY;
      req_valid = 1'b1;
      req_write = write;
      req_addr  = addr;
      req_size  = size;
      req_src   = src;
      @(negedge clk);
      while (!req_ready)
         if (cnt >= TIMEOUT)
            abort_run("req_ready");
         else
         begin
            cnt++;
            @(negedge clk);
         end
      @(posedge clk);
      #DRIVE_DLY req_valid = 1'b0;
   endtask

   // Low word goes first
   task automatic send_beats(input mem_line_t line);
      int cnt;
      for (int b = 0; b < `MEM_LINE_BEATS; b++)
      begin
         cnt = 0;
         wdata_valid = 1'b1;
         wdata       = line[b*`MEM_BEAT_W +: `MEM_BEAT_W];
         @(negedge clk);
         while (!wdata_ready)
            if (cnt >= TIMEOUT)
               abort_run("wdata_ready");
            else
            begin
               cnt++;
               @(negedge clk);
            end
         @(posedge clk);
         #DRIVE_DLY;
      end
      wdata_valid = 1'b0;
   endtask

   task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
      @(posedge clk);
      #DRIVE_DLY;
      cfg_wr_en = 1'b1;
      cfg_addr  = addr;
      cfg_wdata = data;
      @(posedge clk);
      #DRIVE_DLY cfg_wr_en = 1'b0;
   endtask

   task automatic read_and_check(input logic [1:0] addr, input logic [15:0] exp,
                                 input string what);
      @(posedge clk);
      #DRIVE_DLY cfg_addr = addr;
      @(negedge clk);
      check_reg(cfg_rdata, exp, what);
   endtask

   task automatic drain_reads();
      int cnt;
      cnt = 0;
      while (exp_lines.size() != 0)
         if (cnt >= TIMEOUT)
            abort_run("outstanding read responses");
         else
         begin
            cnt++;
            @(negedge clk);
         end
   endtask

   // Random back-pressure on the response channel
   initial
   begin
      seed       = 18485;
      resp_ready = 1'b0;
      forever
      begin
         @(posedge clk);
         #DRIVE_DLY resp_ready = ($random(seed) & 3) != 0;
      end
   end

   //////////////////////////////
   // Response monitor
   //////////////////////////////
   initial
   begin
      int        beat_idx;
      int        rd_errs;
      int        id;
      mem_line_t acc;
      mem_line_t exp_line;
      mem_src_e  exp_src;
      beat_idx = 0;
      rd_errs  = 0;
      acc      = '0;
      forever
      begin
         @(negedge clk);
         if (rst_n && resp_valid && resp_ready)
         begin
            if (exp_lines.size() == 0)
            begin
               $display("[ERROR] %0t: response beat with no read outstanding", $time);
               err_count++;
            end
            else
            begin
               if (beat_idx == 0)
                  rd_errs = err_count;
               acc[beat_idx*`MEM_BEAT_W +: `MEM_BEAT_W] = resp_data;
               check_dest(resp_dest, exp_srcs[0], "resp_dest");
               check_flag(resp_last, beat_idx == 3, "resp_last");
               if (beat_idx == 3)
               begin
                  exp_line = exp_lines.pop_front();
                  exp_src  = exp_srcs.pop_front();
                  id       = exp_ids.pop_front();
                  check_line(acc, exp_line, "read line");
                  report_test($sformatf("read op %0d src %0d", id, exp_src), rd_errs);
                  beat_idx = 0;
               end
               else
                  beat_idx++;
            end
         end
      end
   end

   //////////////////////////////
   // Main sequence
   //////////////////////////////
   initial
   begin
      rst_n       = 1'b0;
      req_valid   = 1'b0;
      req_write   = 1'b0;
      req_addr    = 16'd0;
      req_size    = 4'd0;
      req_src     = src_ic;
      wdata_valid = 1'b0;
      wdata       = '0;
      cfg_wr_en   = 1'b0;
      cfg_addr    = 2'd0;
      cfg_wdata   = 16'd0;

      add_op(op_wr, 16'h0000, 4'd15, src_dc,  4'h1, 16'd0);
      add_op(op_wr, 16'h0010, 4'd15, src_dc,  4'h2, 16'd0);
      add_op(op_wr, 16'h0020, 4'd15, src_dma, 4'h3, 16'd0);
      add_op(op_rd, 16'h0000, 4'd15, src_ic,  4'h0, 16'd0);
      // Partial writes, the third one runs past byte 15
      add_op(op_wr, 16'h0003, 4'd3,  src_dma, 4'h4, 16'd0);
      add_op(op_wr, 16'h0016, 4'd5,  src_dc,  4'h5, 16'd0);
      add_op(op_wr, 16'h002c, 4'd7,  src_dc,  4'h6, 16'd0);
      // Back-to-back reads, the last one aliases line 1
      add_op(op_rd, 16'h0000, 4'd15, src_ic,  4'h0, 16'd0);
      add_op(op_rd, 16'h0010, 4'd15, src_dc,  4'h0, 16'd0);
      add_op(op_rd, 16'h0020, 4'd15, src_dma, 4'h0, 16'd0);
      add_op(op_rd, 16'h1010, 4'd15, src_ic,  4'h0, 16'd0);
      add_op(op_cfg, 16'h0000, 4'd0, src_ic,  4'h0, 16'd1);
      add_op(op_wr, 16'h0001, 4'd0,  src_ic,  4'h7, 16'd0);
      add_op(op_wr, 16'h0030, 4'd15, src_dma, 4'h8, 16'd0);
      add_op(op_rd, 16'h0000, 4'd15, src_dma, 4'h0, 16'd0);
      add_op(op_rd, 16'h0030, 4'd15, src_dc,  4'h0, 16'd0);
      add_op(op_cfg, 16'h0000, 4'd0, src_ic,  4'h0, 16'd9);
      add_op(op_wr, 16'h003a, 4'd9,  src_dc,  4'h9, 16'd0);
      add_op(op_rd, 16'h0030, 4'd15, src_ic,  4'h0, 16'd0);
      add_op(op_rd, 16'h0010, 4'd15, src_dma, 4'h0, 16'd0);
      add_op(op_cfg, 16'h0000, 4'd0, src_ic,  4'h0, 16'd3);
      add_op(op_rd, 16'h0020, 4'd15, src_dc,  4'h0, 16'd0);
      add_op(op_rd, 16'h0000, 4'd15, src_ic,  4'h0, 16'd0);

      repeat (8) @(posedge clk);
      #DRIVE_DLY rst_n = 1'b1;

      // Idle state and register defaults
      errs_before = err_count;
      @(negedge clk);
      check_flag(resp_valid, 1'b0, "resp_valid after reset");
      check_flag(wdata_ready, 1'b0, "wdata_ready after reset");
      check_flag(req_ready, 1'b1, "req_ready after reset");
      read_and_check(`MEM_REG_LATENCY, 16'(`MEM_DEFAULT_LATENCY), "latency after reset");
      read_and_check(`MEM_REG_RD_COUNT, 16'd0, "read count after reset");
      read_and_check(`MEM_REG_WR_COUNT, 16'd0, "write count after reset");
      report_test("reset state", errs_before);

      for (int i = 0; i < n_ops; i++)
      begin
         case (op_kind[i])
            op_cfg:
            begin
               drain_reads();
               errs_before = err_count;
               write_reg(`MEM_REG_LATENCY, op_lat[i]);
               read_and_check(`MEM_REG_LATENCY, op_lat[i], "latency readback");
               report_test($sformatf("latency %0d", op_lat[i]), errs_before);
            end
            op_wr:
            begin
               errs_before = err_count;
               send_header(1'b1, op_addr[i], op_size[i], op_src[i]);
               send_beats(op_line[i]);
               report_test($sformatf("write op %0d addr %h", i, op_addr[i]), errs_before);
            end
            default:
            begin
               exp_lines.push_back(op_exp[i]);
               exp_srcs.push_back(op_src[i]);
               exp_ids.push_back(i);
               send_header(1'b0, op_addr[i], op_size[i], op_src[i]);
            end
         endcase
      end
      drain_reads();

      // Completion counters, then clear by write
      errs_before = err_count;
      read_and_check(`MEM_REG_RD_COUNT, 16'(n_rd), "read count");
      read_and_check(`MEM_REG_WR_COUNT, 16'(n_wr), "write count");
      write_reg(`MEM_REG_RD_COUNT, 16'hffff);
      read_and_check(`MEM_REG_RD_COUNT, 16'd0, "read count after clear");
      read_and_check(`MEM_REG_WR_COUNT, 16'(n_wr), "write count kept");
      write_reg(`MEM_REG_WR_COUNT, 16'h0001);
      read_and_check(`MEM_REG_WR_COUNT, 16'd0, "write count after clear");
      report_test("counters", errs_before);

      $display("%0d tests run, %0d errors", test_count, err_count);
      if (err_count == 0)
         $display("Test completed successfully");
      else
         $display("Test failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+src
src/mem_ctrl_pkg.sv
src/mem_beat_assembler.sv
src/mem_req_latch.sv
src/mem_bank_port.sv
src/mem_ctrl_regs.sv
src/mem_resp_serializer.sv
src/mem_bus_ctrl_top.sv
tb/mem_bus_ctrl_assert.sv
tb/mem_bus_ctrl_tb.sv

// ==== Makefile ====
VERILATOR  = verilator
TOP        = mem_bus_ctrl_tb
FLIST      = flist.f
LINT_FLAGS = --lint-only --timing --assert
SIM_FLAGS  = --binary --timing --assert
PASS_MSG   = Test completed successfully

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
